/* design/predict_pkg.sv */
package predict_pkg;

    localparam int in_side     = 52;  // Input image side
    localparam int img_side    = 28;  // Scaled image side
    localparam int num_classes = 10;
    localparam int score_w     = 16;
    localparam int row_w       = 5;

    // One row of the held image, sent to every neuron
    typedef struct packed {
        logic                valid;
        logic [row_w-1:0]    row;
        logic [img_side-1:0] pixels;  // Bit c is column c
    } row_beat_t;

    typedef logic signed [score_w-1:0] score_t;

    // All neuron scores, cls[n] belongs to digit n
    typedef struct packed {
        score_t [num_classes-1:0] cls;
    } score_vec_t;

    // Ternary weight rule standing in for trained weights
    function automatic logic signed [1:0] weight_of(input int n, input int r, input int c);
        int k;
        k = (r * img_side + c + 11 * n) % 10;
        if (k == 0 || k == 1) begin
            return 2'sd1;
        end else if (k == 9) begin
            return -2'sd1;
        end else begin
            return 2'sd0;
        end
    endfunction

    // Nearest-neighbour source coordinate, floor(i * 52 / 28)
    function automatic int src_index(input int i);
        return (i * in_side) / img_side;
    endfunction

endpackage

/* design/predict_control.sv */
`timescale 1ns/1ns

module predict_control (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    output logic                          capture_en,
    output logic                          row_active,
    output logic [predict_pkg::row_w-1:0] row_idx,
    output logic                          done_pulse
);

    typedef enum logic [1:0] {
        st_wait,
        st_capture,  // Image just taken, first row on the bus
        st_process,
        st_finish
    } state_t;

    state_t                        state;
    logic [predict_pkg::row_w-1:0] row_cnt;
    logic                          last_row;

    assign last_row = (row_cnt == predict_pkg::row_w'(predict_pkg::img_side - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_wait;
            row_cnt <= '0;
        end else begin
            case (state)
                st_wait: begin
                    row_cnt <= '0;
                    if (start) begin
                        state <= st_capture;
                    end
                end
                st_capture: begin
                    state   <= st_process;
                    row_cnt <= row_cnt + 1'b1;
                end
                st_process: begin
                    if (last_row) begin
                        state <= st_finish;  // Row 27 taken on this edge
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end
                default: state <= st_wait;  // st_finish
            endcase
        end
    end

    // start only counts while idle
    assign capture_en = (state == st_wait) && start;
    assign row_active = (state == st_capture) || (state == st_process);
    assign row_idx    = row_cnt;
    assign done_pulse = (state == st_finish);

endmodule

/* design/image_capture.sv */
`timescale 1ns/1ns

module image_capture (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic [predict_pkg::in_side*predict_pkg::in_side-1:0] track_input,
    input  logic                                               capture_en,
    input  logic                                               row_active,
    input  logic [predict_pkg::row_w-1:0]                      row_idx,
    output predict_pkg::row_beat_t                             row_beat
);

    localparam int img_bits = predict_pkg::img_side * predict_pkg::img_side;

    logic [img_bits-1:0] scaled_img;  // Combinational downsample
    logic [img_bits-1:0] held_img;    // Copy taken at capture

    // Pixel (r, c) of the input sits at bit r*52 + c
    for (genvar r = 0; r < predict_pkg::img_side; r++) begin : g_row
        for (genvar c = 0; c < predict_pkg::img_side; c++) begin : g_col
            assign scaled_img[r*predict_pkg::img_side + c] =
                track_input[predict_pkg::src_index(r) * predict_pkg::in_side
                            + predict_pkg::src_index(c)];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held_img <= '0;
        end else if (capture_en) begin
            held_img <= scaled_img;  // Later input changes are ignored
        end
    end

    // Row mux, one held row per cycle
    always_comb begin
        row_beat.valid  = row_active;
        row_beat.row    = row_idx;
        row_beat.pixels = held_img[row_idx*predict_pkg::img_side +: predict_pkg::img_side];
    end

endmodule

/* design/neuron_accumulator.sv */
`timescale 1ns/1ns

module neuron_accumulator #(
    parameter int class_idx = 0  // Digit this neuron scores
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   capture_en,
    input  predict_pkg::row_beat_t row_beat,
    output predict_pkg::score_t    score
);

    predict_pkg::score_t row_sum;  // Weighted sum of the current row
    predict_pkg::score_t acc;

    // Only set pixels contribute, each with its ternary weight
    always_comb begin
        row_sum = '0;
        for (int c = 0; c < predict_pkg::img_side; c++) begin
            if (row_beat.pixels[c]) begin
                row_sum = row_sum
                    + predict_pkg::score_t'(predict_pkg::weight_of(class_idx,
                                                                    int'(row_beat.row), c));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (capture_en) begin
            acc <= '0;  // New image, start over
        end else if (row_beat.valid) begin
            acc <= acc + row_sum;
        end
    end

    assign score = acc;

endmodule

/* design/score_argmax.sv */
`timescale 1ns/1ns

module score_argmax (
    input  logic                    clk,
    input  logic                    rst,
    input  predict_pkg::score_vec_t scores,
    input  logic                    done_pulse,
    output logic [3:0]              predicted_number,
    output logic                    finish
);

    predict_pkg::score_t best_score;
    logic [3:0]          best_idx;

    // Strict greater-than keeps the lowest index on ties
    always_comb begin
        best_score = scores.cls[0];
        best_idx   = 4'd0;
        for (int i = 1; i < predict_pkg::num_classes; i++) begin
            if ($signed(scores.cls[i]) > $signed(best_score)) begin
                best_score = scores.cls[i];
                best_idx   = 4'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            predicted_number <= 4'd0;
            finish           <= 1'b0;
        end else begin
            finish <= done_pulse;  // One-cycle pulse
            if (done_pulse) begin
                predicted_number <= best_idx;  // Held until next result
            end
        end
    end

endmodule

/* design/digit_predictor.sv */
`timescale 1ns/1ns

module digit_predictor (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               start,
    input  logic [predict_pkg::in_side*predict_pkg::in_side-1:0] track_input,
    output logic [3:0]                                         predicted_number,
    output logic                                               finish
);

    logic                          capture_en;
    logic                          row_active;
    logic [predict_pkg::row_w-1:0] row_idx;
    logic                          done_pulse;
    predict_pkg::row_beat_t        row_beat;
    predict_pkg::score_vec_t       scores;

    predict_control u_control (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .capture_en (capture_en),
        .row_active (row_active),
        .row_idx    (row_idx),
        .done_pulse (done_pulse)
    );

    image_capture u_capture (
        .clk         (clk),
        .rst         (rst),
        .track_input (track_input),
        .capture_en  (capture_en),
        .row_active  (row_active),
        .row_idx     (row_idx),
        .row_beat    (row_beat)
    );

    // Single fully connected layer, one neuron per digit
    for (genvar g = 0; g < predict_pkg::num_classes; g++) begin : g_neuron
        neuron_accumulator #(
            .class_idx (g)
        ) u_neuron (
            .clk        (clk),
            .rst        (rst),
            .capture_en (capture_en),
            .row_beat   (row_beat),
            .score      (scores.cls[g])
        );
    end

    score_argmax u_argmax (
        .clk              (clk),
        .rst              (rst),
        .scores           (scores),
        .done_pulse       (done_pulse),
        .predicted_number (predicted_number),
        .finish           (finish)
    );

endmodule

/* dv/predictor_assertions.sv */
`timescale 1ns/1ns

module predictor_assertions (
    input logic       clk,
    input logic       rst,
    input logic       finish,
    input logic [3:0] predicted_number
);

    // finish is a single-cycle pulse
    property finish_one_cycle;
        @(posedge clk) disable iff (rst) finish |=> !finish;
    endproperty

    // Once reset has been seen on an edge, finish stays low
    property finish_low_in_reset;
        @(posedge clk) (rst && $past(rst)) |-> !finish;
    endproperty

    // The result only moves together with finish
    property result_stable;
        @(posedge clk) disable iff (rst) !$stable(predicted_number) |-> finish;
    endproperty

    a_finish_one_cycle: assert property (finish_one_cycle)
        else $error("finish stayed high for more than one cycle");

    a_finish_low_in_reset: assert property (finish_low_in_reset)
        else $error("finish high during reset");

    a_result_stable: assert property (result_stable)
        else $error("predicted_number changed without finish");

endmodule

bind digit_predictor predictor_assertions u_assertions (
    .clk              (clk),
    .rst              (rst),
    .finish           (finish),
    .predicted_number (predicted_number)
);

/* dv/tb_digit_predictor.sv */
`timescale 1ns/1ns

module tb_digit_predictor;

    localparam int in_bits     = predict_pkg::in_side * predict_pkg::in_side;
    localparam int num_entries = 8;

    typedef struct packed {
        logic [2:0] kind;   // Image pattern from build_image
        logic [3:0] delay;  // Idle cycles before start
    } entry_t;

    logic               clk;
    logic               rst;
    logic               start;
    logic [in_bits-1:0] track_input;
    logic [3:0]         predicted_number;
    logic               finish;

    entry_t             table_q [num_entries];
    logic [in_bits-1:0] image;
    int                 seed;
    int                 errors;
    int                 checks;
    int                 last_digit;  // Last result that must hold between runs
    bit                 timed_out;

    digit_predictor UUT (
        .clk              (clk),
        .rst              (rst),
        .start            (start),
        .track_input      (track_input),
        .predicted_number (predicted_number),
        .finish           (finish)
    );

    always #5 clk = ~clk;

    // Nearest-neighbour pick as floor(i*52/28)
    function automatic int source_coord(input int i);
        return (i * 52) / 28;
    endfunction

    function automatic int ternary_weight(input int n, input int r, input int c);
        int k;
        k = (r * 28 + c + 11 * n) % 10;
        case (k)
            0, 1:    return 1;
            9:       return -1;
            default: return 0;
        endcase
    endfunction

    // Reference model of the whole layer plus argmax
    function automatic int predict_digit(input logic [in_bits-1:0] img);
        int score [10];
        int best;
        for (int n = 0; n < 10; n++) begin
            score[n] = 0;
            for (int r = 0; r < 28; r++) begin
                for (int c = 0; c < 28; c++) begin
                    if (img[source_coord(r) * 52 + source_coord(c)]) begin
                        score[n] += ternary_weight(n, r, c);
                    end
                end
            end
        end
        best = 0;
        for (int n = 1; n < 10; n++) begin
            if (score[n] > score[best]) begin
                best = n;  // Strictly greater keeps the lowest index on ties
            end
        end
        return best;
    endfunction

    // Pixel (r, c) of the 52x52 image is bit r*52 + c
    task automatic build_image(input logic [2:0] kind, output logic [in_bits-1:0] img);
        int bit_val;
        img = '0;
        for (int r = 0; r < 52; r++) begin
            for (int c = 0; c < 52; c++) begin
                case (kind)
                    3'd1:       bit_val = 1;
                    3'd2:       bit_val = (c >= 20 && c < 32);     // Vertical bar
                    3'd3:       bit_val = (r >= 20 && r < 32);     // Horizontal bar
                    3'd4:       bit_val = (r - c <= 3 && c - r <= 3);
                    3'd5:       bit_val = (r + c) % 2;
                    3'd6, 3'd7: bit_val = $random(seed) & 1;
                    default:    bit_val = 0;                       // Blank
                endcase
                img[r * 52 + c] = bit_val[0];
            end
        end
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("FAILED at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic run_entry(input entry_t entry);
        int expected;
        int count;
        build_image(entry.kind, image);
        expected = predict_digit(image);
        for (int i = 0; i < int'(entry.delay); i++) begin
            @(negedge clk);
            check_value("predicted_number", last_digit, int'(predicted_number));
        end
        track_input = image;
        start       = 1'b1;
        @(negedge clk);  // E0 has passed
        start = 1'b0;
        check_value("finish", 0, int'(finish));
        count = 0;
        while (!finish && count < 100) begin
            @(negedge clk);
            count++;
            if (count == 5) begin
                track_input = ~image;  // Must not reach the held copy
            end
            start = (count == 5 || count == 28);  // Both pulses are ignored
            if (!finish) begin
                check_value("predicted_number", last_digit, int'(predicted_number));
            end
        end
        if (!finish) begin
            timed_out = 1'b1;
            errors++;
            $display("Timeout: finish did not rise within 100 cycles of start");
        end else begin
            check_value("finish edges after start", 29, count);
            if (entry.kind == 3'd0) begin
                // No set pixel, so every neuron ends at zero
                for (int n = 0; n < predict_pkg::num_classes; n++) begin
                    check_value($sformatf("scores.cls[%0d]", n), 0,
                                int'(UUT.scores.cls[n]));
                end
            end
            check_value("predicted_number", expected, int'(predicted_number));
            last_digit = int'(predicted_number);
        end
    endtask

    initial begin
        seed        = 32'h1f85;
        errors      = 0;
        checks      = 0;
        last_digit  = 0;
        timed_out   = 1'b0;
        clk         = 1'b0;
        rst         = 1'b1;
        start       = 1'b0;
        track_input = '0;

        table_q[0] = '{kind: 3'd0, delay: 4'd2};  // Blank
        table_q[1] = '{kind: 3'd1, delay: 4'd0};  // All ones back to back
        table_q[2] = '{kind: 3'd2, delay: 4'd3};
        table_q[3] = '{kind: 3'd3, delay: 4'd1};
        table_q[4] = '{kind: 3'd4, delay: 4'd0};
        table_q[5] = '{kind: 3'd5, delay: 4'd5};  // Checkerboard
        table_q[6] = '{kind: 3'd6, delay: 4'd0};
        table_q[7] = '{kind: 3'd7, delay: 4'd4};

        repeat (3) @(negedge clk);
        rst = 1'b0;
        check_value("finish", 0, int'(finish));
        check_value("predicted_number", 0, int'(predicted_number));

        for (int i = 0; i < num_entries && !timed_out; i++) begin
            run_entry(table_q[i]);
        end

        // Result holds while idle
        repeat (3) begin
            @(negedge clk);
            check_value("finish", 0, int'(finish));
            check_value("predicted_number", last_digit, int'(predicted_number));
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
design/predict_pkg.sv
design/predict_control.sv
design/image_capture.sv
design/neuron_accumulator.sv
design/score_argmax.sv
design/digit_predictor.sv
dv/predictor_assertions.sv
dv/tb_digit_predictor.sv

/* Makefile */
# Verilator build and run of the digit predictor testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f tb.f --top-module tb_digit_predictor -Mdir obj_dir

run: compile
	-./obj_dir/Vtb_digit_predictor > sim.log 2>&1
	cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
